// ==== source/isaPkg.sv ====
package isaPkg;

  // Primary opcode field, instr[31:26]
  typedef enum logic [5:0] {
    opRType  = 6'b000000,
    opRegimm = 6'b000001,
    opJ      = 6'b000010,
    opJal    = 6'b000011,
    opBeq    = 6'b000100,
    opBne    = 6'b000101,
    opBlez   = 6'b000110,
    opBgtz   = 6'b000111,
    opAddiu  = 6'b001001,
    opSlti   = 6'b001010,
    opSltiu  = 6'b001011,
    opAndi   = 6'b001100,
    opOri    = 6'b001101,
    opXori   = 6'b001110,
    opLui    = 6'b001111,
    opLb     = 6'b100000,
    opLh     = 6'b100001,
    opLw     = 6'b100011,
    opLbu    = 6'b100100,
    opLhu    = 6'b100101,
    opSb     = 6'b101000,
    opSh     = 6'b101001,
    opSw     = 6'b101011
  } opcodeT;

  // Funct codes with their own control flow, all others are ALU ops
  typedef enum logic [5:0] {
    functJr   = 6'b001000,
    functJalr = 6'b001001
  } functT;

  // The rt field selects the branch under REGIMM
  typedef enum logic [4:0] {
    rtBltz   = 5'b00000,
    rtBgez   = 5'b00001,
    rtBltzal = 5'b10000,
    rtBgezal = 5'b10001
  } regimmT;

  typedef logic [31:0] instrT;

  typedef enum logic [2:0] {
    clsNop, clsAluReg, clsAluImm, clsLoad, clsStore, clsBranch, clsJump, clsJumpReg
  } instrClassT;

  typedef enum logic [2:0] {
    condNever, condEq, condNe, condLez, condGtz, condLtz, condGez, condAlways
  } branchCondT;

  typedef enum logic [1:0] {
    sizeWord, sizeHalf, sizeByte
  } accessSizeT;

endpackage

// ==== source/controlPkg.sv ====
package controlPkg;

  // FSM state codes, fixed to the encoding seen on the state output
  typedef enum logic [2:0] {
    FETCH  = 3'b000,
    DECODE = 3'b001,
    EXEC1  = 3'b010,
    EXEC2  = 3'b011,
    EXEC3  = 3'b100,
    HALTED = 3'b101,
    STALL  = 3'b110
  } cpuStateT;

  // Number of execute steps, 1 to 3
  typedef logic [1:0] stepCountT;

  // One bit per byte lane of the data bus
  typedef logic [3:0] byteEnableT;

  // Upper bit means sign extend, lower bit picks half over byte
  typedef enum logic [1:0] {
    extNone     = 2'b00,
    extSignByte = 2'b10,
    extSignHalf = 2'b11
  } loadExtendT;

endpackage

// ==== source/instrClassifier.sv ====
`timescale 1ns/1ns

module instrClassifier
  import isaPkg::*;
  import controlPkg::*;
(
  input  instrT      instr,
  output instrClassT instrClass,
  output stepCountT  stepCount,
  output accessSizeT accessSize,
  output logic       signedLoad,
  output branchCondT branchCond,
  output logic       linkWrite,
  output logic       regDst
);

  logic [5:0] opcode;
  logic [5:0] funct;
  logic [4:0] rtField;

  assign opcode  = instr[31:26];
  assign funct   = instr[5:0];
  assign rtField = instr[20:16];

  always_comb begin
    // Unknown encodings fall through as a single-step no-op
    instrClass = clsNop;
    stepCount  = 2'd1;
    accessSize = sizeWord;
    signedLoad = 1'b0;
    branchCond = condNever;
    linkWrite  = 1'b0;
    regDst     = 1'b0;

    case (opcode)
      opRType: begin
        regDst = 1'b1;
        if (funct == functJr) begin
          instrClass = clsJumpReg;
          branchCond = condAlways;
        end else if (funct == functJalr) begin
          // Return address written in EXEC1, jump resolved in EXEC2
          instrClass = clsJumpReg;
          stepCount  = 2'd2;
          branchCond = condAlways;
          linkWrite  = 1'b1;
        end else begin
          instrClass = clsAluReg;
          stepCount  = 2'd2;
        end
      end
      opRegimm: begin
        case (rtField)
          rtBltz: begin
            instrClass = clsBranch;
            branchCond = condLtz;
          end
          rtBgez: begin
            instrClass = clsBranch;
            branchCond = condGez;
          end
          rtBltzal, rtBgezal: begin
            instrClass = clsBranch;
            stepCount  = 2'd2;
            branchCond = rtField[0] ? condGez : condLtz;
            linkWrite  = 1'b1;
          end
          default: instrClass = clsNop;
        endcase
      end
      opJ: begin
        instrClass = clsJump;
        branchCond = condAlways;
      end
      opJal: begin
        instrClass = clsJump;
        stepCount  = 2'd2;
        branchCond = condAlways;
        linkWrite  = 1'b1;
      end
      opBeq, opBne, opBlez, opBgtz: begin
        instrClass = clsBranch;
        case (opcode)
          opBeq:   branchCond = condEq;
          opBne:   branchCond = condNe;
          opBlez:  branchCond = condLez;
          default: branchCond = condGtz;
        endcase
      end
      opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui: begin
        instrClass = clsAluImm;
        stepCount  = 2'd2;
      end
      opLb, opLh, opLw, opLbu, opLhu: begin
        // Address, memory read, then register write
        instrClass = clsLoad;
        stepCount  = 2'd3;
        signedLoad = (opcode == opLb) || (opcode == opLh);
        if (opcode == opLb || opcode == opLbu) begin
          accessSize = sizeByte;
        end else if (opcode == opLh || opcode == opLhu) begin
          accessSize = sizeHalf;
        end
      end
      opSb, opSh, opSw: begin
        instrClass = clsStore;
        stepCount  = 2'd2;
        if (opcode == opSb) begin
          accessSize = sizeByte;
        end else if (opcode == opSh) begin
          accessSize = sizeHalf;
        end
      end
      default: instrClass = clsNop;
    endcase
  end

endmodule

// ==== source/controlSequencer.sv ====
`timescale 1ns/1ns

module controlSequencer
  import controlPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      start,
  input  logic      pcIsZero,
  input  logic      waitrequest,
  input  logic      stall,
  input  stepCountT stepCount,
  output cpuStateT  state,
  output logic      instrDone
);

  cpuStateT stateNext;

  always_comb begin
    stateNext = state;
    if (state == HALTED) begin
      if (start) begin
        stateNext = FETCH;
      end
    end else if (pcIsZero) begin
      // A zero PC halts from anywhere, ahead of all other rules
      stateNext = HALTED;
    end else begin
      case (state)
        FETCH, STALL: stateNext = waitrequest ? STALL : DECODE;
        DECODE:       stateNext = EXEC1;
        EXEC1: begin
          if (!stall) begin
            stateNext = (stepCount > 2'd1) ? EXEC2 : FETCH;
          end
        end
        EXEC2: begin
          // Memory access step, held until the bus is ready
          if (!waitrequest) begin
            stateNext = (stepCount == 2'd3) ? EXEC3 : FETCH;
          end
        end
        EXEC3:   stateNext = FETCH;
        default: stateNext = HALTED;
      endcase
    end
  end

  // Only an execute step ever returns to FETCH, HALTED is excluded for start
  assign instrDone = (stateNext == FETCH) && (state != HALTED);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= HALTED;
    end else begin
      state <= stateNext;
    end
  end

endmodule

// ==== source/branchResolver.sv ====
`timescale 1ns/1ns

module branchResolver
  import isaPkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       instrDone,
  input  logic       aluLsb,
  input  logic       lessThan,
  input  branchCondT branchCond,
  output logic       branchDelay
);

  logic taken;

  // aluLsb carries the equality or less-or-equal compare from the ALU
  always_comb begin
    case (branchCond)
      condAlways: taken = 1'b1;
      condEq:     taken = aluLsb;
      condNe:     taken = !aluLsb;
      condLez:    taken = aluLsb;
      condGtz:    taken = !aluLsb;
      condLtz:    taken = lessThan;
      condGez:    taken = !lessThan;
      default:    taken = 1'b0;
    endcase
  end

  // Decision kept until the next instruction completes
  always_ff @(posedge clk) begin
    if (rst) begin
      branchDelay <= 1'b0;
    end else if (instrDone) begin
      branchDelay <= taken;
    end
  end

endmodule

// ==== source/strobeGenerator.sv ====
`timescale 1ns/1ns

module strobeGenerator
  import isaPkg::*;
  import controlPkg::*;
(
  input  cpuStateT   state,
  input  instrClassT instrClass,
  input  accessSizeT accessSize,
  input  logic       signedLoad,
  input  logic       linkWrite,
  input  logic       regDstIn,
  input  logic       branchDelay,
  output logic       memRead,
  output logic       memWrite,
  output logic       irWrite,
  output logic       pcWrite,
  output logic       regWrite,
  output logic       regDst,
  output logic       link,
  output logic       isJump,
  output logic       pcSrc,
  output logic       active,
  output byteEnableT byteEnable,
  output loadExtendT loadExtend
);

  logic isLoad;
  logic isStore;
  logic isAlu;

  assign isLoad  = (instrClass == clsLoad);
  assign isStore = (instrClass == clsStore);
  assign isAlu   = (instrClass == clsAluReg) || (instrClass == clsAluImm);

  // Instruction fetch occupies the bus in FETCH and STALL
  assign memRead  = (state == FETCH) || (state == STALL) || (isLoad && state == EXEC2);
  assign memWrite = isStore && (state == EXEC2);

  always_comb begin
    byteEnable = 4'b1111;
    if ((isLoad || isStore) && state == EXEC2) begin
      case (accessSize)
        sizeHalf: byteEnable = 4'b0011;
        sizeByte: byteEnable = 4'b0001;
        default:  byteEnable = 4'b1111;
      endcase
    end
  end

  // Extension stays valid from the read into the writeback step
  always_comb begin
    loadExtend = extNone;
    if (isLoad && signedLoad && (state == EXEC2 || state == EXEC3)) begin
      if (accessSize == sizeByte) begin
        loadExtend = extSignByte;
      end else if (accessSize == sizeHalf) begin
        loadExtend = extSignHalf;
      end
    end
  end

  assign irWrite = (state == DECODE);
  assign pcWrite = (state == FETCH);
  assign pcSrc   = (state == FETCH) && branchDelay;

  assign regWrite = (isAlu && state == EXEC2) || (isLoad && state == EXEC3)
                  || (linkWrite && state == EXEC1);

  // JALR writes rd through regDst, not the fixed link register
  assign link   = linkWrite && (state == EXEC1) && (instrClass != clsJumpReg);
  assign isJump = (instrClass == clsJump)
                  && ((state == EXEC1 && !linkWrite) || (state == EXEC2 && linkWrite));

  assign regDst = regDstIn;
  assign active = (state != HALTED);

endmodule

// ==== source/controlDecoder.sv ====
`timescale 1ns/1ns

module controlDecoder
  import isaPkg::*;
  import controlPkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       start,
  input  instrT      instr,
  input  logic       waitrequest,
  input  logic       stall,
  input  logic       pcIsZero,
  input  logic       aluLsb,
  input  logic       lessThan,
  output logic       memRead,
  output logic       memWrite,
  output logic       irWrite,
  output logic       pcWrite,
  output logic       regWrite,
  output logic       regDst,
  output logic       link,
  output logic       isJump,
  output logic       pcSrc,
  output logic       active,
  output byteEnableT byteEnable,
  output loadExtendT loadExtend,
  output cpuStateT   state,
  output logic       branchDelay
);

  instrClassT instrClass;
  stepCountT  stepCount;
  accessSizeT accessSize;
  logic       signedLoad;
  branchCondT branchCond;
  logic       linkWrite;
  logic       regDstDecoded;
  logic       instrDone;

  instrClassifier u_instrClassifier (
    .instr      (instr),
    .instrClass (instrClass),
    .stepCount  (stepCount),
    .accessSize (accessSize),
    .signedLoad (signedLoad),
    .branchCond (branchCond),
    .linkWrite  (linkWrite),
    .regDst     (regDstDecoded)
  );

  controlSequencer u_controlSequencer (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .pcIsZero    (pcIsZero),
    .waitrequest (waitrequest),
    .stall       (stall),
    .stepCount   (stepCount),
    .state       (state),
    .instrDone   (instrDone)
  );

  branchResolver u_branchResolver (
    .clk         (clk),
    .rst         (rst),
    .instrDone   (instrDone),
    .aluLsb      (aluLsb),
    .lessThan    (lessThan),
    .branchCond  (branchCond),
    .branchDelay (branchDelay)
  );

  strobeGenerator u_strobeGenerator (
    .state       (state),
    .instrClass  (instrClass),
    .accessSize  (accessSize),
    .signedLoad  (signedLoad),
    .linkWrite   (linkWrite),
    .regDstIn    (regDstDecoded),
    .branchDelay (branchDelay),
    .memRead     (memRead),
    .memWrite    (memWrite),
    .irWrite     (irWrite),
    .pcWrite     (pcWrite),
    .regWrite    (regWrite),
    .regDst      (regDst),
    .link        (link),
    .isJump      (isJump),
    .pcSrc       (pcSrc),
    .active      (active),
    .byteEnable  (byteEnable),
    .loadExtend  (loadExtend)
  );

endmodule

// ==== bench/controlDecoder_props.sv ====
`timescale 1ns/1ns

module controlDecoderProps
  import controlPkg::*;
(
  input logic     clk,
  input logic     rst,
  input logic     memRead,
  input logic     memWrite,
  input logic     irWrite,
  input logic     active,
  input cpuStateT state
);

  // Assertion failures seen so far
  int failCount = 0;

  // One bus direction per cycle
  noReadWrite: assert property (@(posedge clk) disable iff (rst) !(memRead && memWrite))
    else begin
      failCount++;
      $error("memRead and memWrite high in the same cycle");
    end

  // The instruction register loads only in DECODE
  irThenExec: assert property (@(posedge clk) disable iff (rst)
      irWrite |=> (state == EXEC1 || state == HALTED))
    else begin
      failCount++;
      $error("irWrite not followed by EXEC1 or HALTED");
    end

  activeMatch: assert property (@(posedge clk) disable iff (rst) active == (state != HALTED))
    else begin
      failCount++;
      $error("active does not match the HALTED state");
    end

endmodule

bind controlDecoder controlDecoderProps u_props (
  .clk      (clk),
  .rst      (rst),
  .memRead  (memRead),
  .memWrite (memWrite),
  .irWrite  (irWrite),
  .active   (active),
  .state    (state)
);

// ==== bench/controlDecoderTb.sv ====
`timescale 1ns/1ns

module controlDecoderTb
  import isaPkg::*;
  import controlPkg::*;
();

  localparam int numInstr       = 400;
  localparam int cyclesPerInstr = 20;
  localparam int cycleLimit     = numInstr * cyclesPerInstr;

  logic       clk;
  logic       rst;
  logic       start;
  instrT      instr;
  logic       waitrequest;
  logic       stall;
  logic       pcIsZero;
  logic       aluLsb;
  logic       lessThan;
  logic       memRead;
  logic       memWrite;
  logic       irWrite;
  logic       pcWrite;
  logic       regWrite;
  logic       regDst;
  logic       link;
  logic       isJump;
  logic       pcSrc;
  logic       active;
  byteEnableT byteEnable;
  loadExtendT loadExtend;
  cpuStateT   state;
  logic       branchDelay;

  // Reference model state
  cpuStateT   modelState;
  cpuStateT   nextState;
  logic       modelDelay;
  logic       nextDelay;
  int         errorCount;
  int         doneCount;
  int         cycleCount;
  int         resetLeft;

  // Decoded view of the current instruction
  logic       refRType;
  logic       refLoad;
  logic       refStore;
  logic       refSigned;
  logic       refAlu;
  logic       refJump;
  logic       refJalr;
  logic       refLinkWr;
  stepCountT  refSteps;
  accessSizeT refSize;
  branchCondT refCond;

  opcodeT opList [23] = '{opRType, opRegimm, opJ, opJal, opBeq, opBne, opBlez, opBgtz,
                          opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui, opLb,
                          opLh, opLw, opLbu, opLhu, opSb, opSh, opSw};

  controlDecoder u_controlDecoder (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errorCount++;
      $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic checkState(input string name, input cpuStateT got, input cpuStateT exp);
    if (got !== exp) begin
      errorCount++;
      $display("error at %0t: %s is %s (%b), expected %s (%b)", $time, name, got.name(), got,
               exp.name(), exp);
    end
  endtask

  task automatic checkByteEnable(input string name, input byteEnableT got, input byteEnableT exp);
    if (got !== exp) begin
      errorCount++;
      $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic checkExtend(input string name, input loadExtendT got, input loadExtendT exp);
    if (got !== exp) begin
      errorCount++;
      $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  function automatic instrT randomInstr();
    instrT      w;
    logic [4:0] idx;
    w   = $urandom;
    idx = 5'($urandom % 24);
    // Index 23 keeps a random opcode, usually an unknown one
    if (idx < 5'd23) begin
      w[31:26] = opList[idx];
    end
    if (w[31:26] == opRType && ($urandom % 2) == 0) begin
      w[5:0] = (($urandom % 2) == 0) ? functJr : functJalr;
    end
    if (w[31:26] == opRegimm && ($urandom % 4) != 0) begin
      w[20:16] = 5'(($urandom % 2) + 16 * ($urandom % 2));
    end
    return w;
  endfunction

  task automatic decodeRef(input instrT w);
    logic [5:0] op;
    logic       regimmBranch;
    logic       jr;
    op           = w[31:26];
    regimmBranch = (op == opRegimm) && (w[20:16] inside {rtBltz, rtBgez, rtBltzal, rtBgezal});
    refRType     = (op == opRType);
    jr           = refRType && (w[5:0] == functJr);
    refJalr      = refRType && (w[5:0] == functJalr);
    refLoad      = op inside {opLb, opLh, opLw, opLbu, opLhu};
    refStore     = op inside {opSb, opSh, opSw};
    refSigned    = op inside {opLb, opLh};
    refJump      = op inside {opJ, opJal};
    refAlu       = (refRType && !jr && !refJalr)
                   || (op inside {opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui});
    // BLTZAL and BGEZAL have rt bit 4 set
    refLinkWr    = (op == opJal) || refJalr || (regimmBranch && w[20]);
    refSize      = sizeWord;
    if (op inside {opLb, opLbu, opSb}) begin
      refSize = sizeByte;
    end else if (op inside {opLh, opLhu, opSh}) begin
      refSize = sizeHalf;
    end
    refSteps = 2'd1;
    if (refLoad) begin
      refSteps = 2'd3;
    end else if (refStore || refAlu || refLinkWr) begin
      refSteps = 2'd2;
    end
    case (op)
      opBeq:       refCond = condEq;
      opBne:       refCond = condNe;
      opBlez:      refCond = condLez;
      opBgtz:      refCond = condGtz;
      opJ, opJal:  refCond = condAlways;
      opRType:     refCond = (jr || refJalr) ? condAlways : condNever;
      opRegimm:    refCond = !regimmBranch ? condNever : (w[16] ? condGez : condLtz);
      default:     refCond = condNever;
    endcase
  endtask

  function automatic logic takenRef(input branchCondT c, input logic eq, input logic lt);
    case (c)
      condEq, condLez: return eq;
      condNe, condGtz: return !eq;
      condLtz:         return lt;
      condGez:         return !lt;
      condAlways:      return 1'b1;
      default:         return 1'b0;
    endcase
  endfunction

  task automatic driveInputs();
    rst = (resetLeft > 0);
    if (resetLeft > 0) begin
      resetLeft--;
    end
    start       = !rst && (modelState == HALTED) && (($urandom % 2) == 0);
    pcIsZero    = !rst && (modelState != HALTED) && (($urandom % 600) == 0);
    waitrequest = ($urandom % 4) == 0;
    stall       = ($urandom % 5) == 0;
    aluLsb      = ($urandom % 2) == 0;
    lessThan    = ($urandom % 2) == 0;
    if (modelState == FETCH || modelState == STALL) begin
      instr = randomInstr();
    end
  endtask

  task automatic stepModel();
    decodeRef(instr);
    nextState = modelState;
    nextDelay = modelDelay;
    if (rst) begin
      nextState = HALTED;
      nextDelay = 1'b0;
    end else if (modelState == HALTED) begin
      if (start) begin
        nextState = FETCH;
      end
    end else if (pcIsZero) begin
      nextState = HALTED;
    end else begin
      case (modelState)
        FETCH, STALL: nextState = waitrequest ? STALL : DECODE;
        DECODE:       nextState = EXEC1;
        EXEC1:        nextState = stall ? EXEC1 : ((refSteps == 2'd1) ? FETCH : EXEC2);
        EXEC2:        nextState = waitrequest ? EXEC2 : ((refSteps == 2'd3) ? EXEC3 : FETCH);
        default:      nextState = FETCH;
      endcase
      // Completion latches the branch decision
      if (nextState == FETCH) begin
        nextDelay = takenRef(refCond, aluLsb, lessThan);
        doneCount++;
      end
    end
  endtask

  task automatic checkOutputs();
    logic [1:0] stepNow;
    byteEnableT expBe;
    loadExtendT expExt;
    decodeRef(instr);
    case (modelState)
      EXEC1:   stepNow = 2'd1;
      EXEC2:   stepNow = 2'd2;
      EXEC3:   stepNow = 2'd3;
      default: stepNow = 2'd0;
    endcase
    expBe = 4'b1111;
    if ((refLoad || refStore) && stepNow == 2'd2) begin
      expBe = (refSize == sizeByte) ? 4'b0001 : ((refSize == sizeHalf) ? 4'b0011 : 4'b1111);
    end
    expExt = extNone;
    if (refLoad && refSigned && stepNow >= 2'd2) begin
      expExt = (refSize == sizeByte) ? extSignByte : extSignHalf;
    end
    checkState("state", state, modelState);
    checkBit("branchDelay", branchDelay, modelDelay);
    checkBit("memRead", memRead, (modelState inside {FETCH, STALL}) || (refLoad && stepNow == 2'd2));
    checkBit("memWrite", memWrite, refStore && stepNow == 2'd2);
    checkByteEnable("byteEnable", byteEnable, expBe);
    checkExtend("loadExtend", loadExtend, expExt);
    checkBit("irWrite", irWrite, modelState == DECODE);
    checkBit("pcWrite", pcWrite, modelState == FETCH);
    checkBit("pcSrc", pcSrc, (modelState == FETCH) && modelDelay);
    checkBit("regWrite", regWrite, (refAlu && stepNow == 2'd2) || (refLoad && stepNow == 2'd3)
             || (refLinkWr && stepNow == 2'd1));
    checkBit("regDst", regDst, refRType);
    checkBit("link", link, refLinkWr && !refJalr && stepNow == 2'd1);
    checkBit("isJump", isJump, refJump && stepNow == refSteps);
    checkBit("active", active, modelState != HALTED);
  endtask

  task automatic runCycle();
    @(negedge clk);
    driveInputs();
    stepModel();
    @(posedge clk);
    #2;
    modelState = nextState;
    modelDelay = nextDelay;
    checkOutputs();
  endtask

  initial begin
    cycleCount = 0;
    while (cycleCount < cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: the run hung, only %0d of %0d instructions done after %0d cycles",
             doneCount, numInstr, cycleCount);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    void'($urandom(32'h5209_ba40));
    rst         = 1'b1;
    start       = 1'b0;
    instr       = '0;
    waitrequest = 1'b0;
    stall       = 1'b0;
    pcIsZero    = 1'b0;
    aluLsb      = 1'b0;
    lessThan    = 1'b0;
    errorCount  = 0;
    doneCount   = 0;
    modelState  = HALTED;
    modelDelay  = 1'b0;
    // The edge before the first cycle is the first of five in reset
    resetLeft   = 4;
    while (doneCount < numInstr) begin
      runCycle();
    end
    $display("Run of %0d instructions: %0d compare errors, %0d assertion failures", doneCount,
             errorCount, u_controlDecoder.u_props.failCount);
    if (errorCount == 0 && u_controlDecoder.u_props.failCount == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
source/isaPkg.sv
source/controlPkg.sv
source/instrClassifier.sv
source/controlSequencer.sv
source/branchResolver.sv
source/strobeGenerator.sv
source/controlDecoder.sv
bench/controlDecoder_props.sv
bench/controlDecoderTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the controlDecoder testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert --top-module controlDecoderTb \
  -f verilog.f -Mdir "$buildDir" -o controlDecoderSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Let assertion failures be counted instead of stopping the run
"./$buildDir/controlDecoderSim" +verilator+error+limit+1000 > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q "Simulation finished: PASS" "$logFile"; then
  exit 0
fi
echo "Pass message not found in $logFile"
exit 1
